// ==== Makefile ====
TOP   = tb_ooo_core
BUILD = build

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module $(TOP) -Mdir $(BUILD)
	@out=$$(./$(BUILD)/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf $(BUILD)

// ==== flist.f ====
src/ooo_pkg.sv
src/rename_table.sv
src/reservation_station.sv
src/alu_unit.sv
src/mult_unit.sv
src/cdb_arbiter.sv
src/reorder_buffer.sv
src/ooo_core.sv
verification/clock_gen.sv
verification/commit_checker.sv
verification/ooo_core_properties.sv
verification/tb_ooo_core.sv

// ==== src/alu_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
    input  wire logic          clock,
    input  wire logic          reset,
    input  ooo_pkg::exec_req_t req,
    input  wire logic          grant,
    output logic               busy,
    output ooo_pkg::cdb_t      result
);
    import ooo_pkg::*;

    // result waits here while the bus goes to the multiplier
    assign busy = result.valid && !grant;

    always_ff @(posedge clock) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else if (!busy) begin
            result.valid <= req.valid;   // drops once granted and idle
            result.tag   <= req.tag;
            result.value <= alu_result(req.opcode, req.a, req.b);
        end
    end

endmodule

`default_nettype wire

// ==== src/cdb_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module cdb_arbiter (
    input  ooo_pkg::cdb_t alu_result,
    input  ooo_pkg::cdb_t mult_result,
    output logic          alu_grant,
    output ooo_pkg::cdb_t cdb
);
    import ooo_pkg::*;

    // multiplier pipeline cannot hold, so it always wins
    always_comb begin
        alu_grant = alu_result.valid && !mult_result.valid;
        if (mult_result.valid)
            cdb = mult_result;
        else
            cdb = alu_result;          // valid low when alu idle too
    end

endmodule

`default_nettype wire

// ==== src/mult_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module mult_unit #(
    parameter int MULT_LATENCY = 3
) (
    input  wire logic          clock,
    input  wire logic          reset,
    input  ooo_pkg::exec_req_t req,
    output ooo_pkg::cdb_t      result
);
    import ooo_pkg::*;

    logic [2*data_width-1:0] product;
    cdb_t                    stage [MULT_LATENCY];

    assign product = req.a * req.b;

    ////////////////////////////////////////////////////////////
    // product in stage 0, then just carried along
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MULT_LATENCY; i++)
                stage[i].valid <= 1'b0;
        end else begin
            stage[0].valid <= req.valid;
            for (int i = 1; i < MULT_LATENCY; i++)
                stage[i].valid <= stage[i-1].valid;
        end
        stage[0].tag   <= req.tag;
        stage[0].value <= product[data_width-1:0];   // low half, wraps
        for (int i = 1; i < MULT_LATENCY; i++) begin
            stage[i].tag   <= stage[i-1].tag;
            stage[i].value <= stage[i-1].value;
        end
    end

    assign result = stage[MULT_LATENCY-1];   // never stalled

endmodule

`default_nettype wire

// ==== src/ooo_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module ooo_core #(
    parameter int ROB_DEPTH    = 8,
    parameter int RS_DEPTH     = 4,
    parameter int MULT_LATENCY = 3
) (
    input  wire logic           clock,
    input  wire logic           reset,
    input  ooo_pkg::inst_word_u in_inst,
    input  wire logic           in_valid,
    output logic                in_ready,
    output ooo_pkg::commit_t    commit
);
    import ooo_pkg::*;

    logic                                   dispatch;
    logic                                   rob_full, rs_full;
    rob_tag_t                               alloc_tag, retire_tag;
    logic [max_rob_depth-1:0]               rob_done;
    logic [max_rob_depth-1:0][data_width-1:0] rob_values;
    operand_t                               src1, src2;
    rs_entry_t                              rs_insert;
    exec_req_t                              alu_req, mult_req;
    logic                                   alu_busy, alu_grant;
    cdb_t                                   alu_cdb, mult_cdb, cdb;

    assign in_ready  = !rob_full && !rs_full;
    assign dispatch  = in_valid && in_ready;
    assign rs_insert = '{opcode: in_inst.r_form.opcode, tag: alloc_tag,
                         src1: src1, src2: src2};

    ////////////////////////////////////////////////////////////
    // dispatch and rename
    rename_table i_rename_table (
        .clock(clock), .reset(reset),
        .dispatch_valid(dispatch), .dispatch_inst(in_inst), .dispatch_tag(alloc_tag),
        .rob_done(rob_done), .rob_values(rob_values), .cdb(cdb),
        .retire(commit), .retire_tag(retire_tag),
        .src1(src1), .src2(src2)
    );

    reservation_station #(.RS_DEPTH(RS_DEPTH)) i_reservation_station (
        .clock(clock), .reset(reset),
        .insert_valid(dispatch), .insert(rs_insert), .cdb(cdb), .alu_busy(alu_busy),
        .full(rs_full), .alu_req(alu_req), .mult_req(mult_req)
    );

    ////////////////////////////////////////////////////////////
    // execute, shared bus, retire
    alu_unit i_alu_unit (
        .clock(clock), .reset(reset),
        .req(alu_req), .grant(alu_grant), .busy(alu_busy), .result(alu_cdb)
    );

    mult_unit #(.MULT_LATENCY(MULT_LATENCY)) i_mult_unit (
        .clock(clock), .reset(reset), .req(mult_req), .result(mult_cdb)
    );

    cdb_arbiter i_cdb_arbiter (
        .alu_result(alu_cdb), .mult_result(mult_cdb), .alu_grant(alu_grant), .cdb(cdb)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) i_reorder_buffer (
        .clock(clock), .reset(reset),
        .alloc_valid(dispatch), .alloc_rd(in_inst.r_form.rd), .cdb(cdb),
        .full(rob_full), .alloc_tag(alloc_tag), .done(rob_done), .values(rob_values),
        .retire(commit), .retire_tag(retire_tag)
    );

endmodule

`default_nettype wire

// ==== src/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    localparam int data_width    = 16;
    localparam int arch_regs     = 8;
    localparam int max_rob_depth = 8;   // sets the tag width

    typedef logic [$clog2(arch_regs)-1:0]     arch_idx_t;
    typedef logic [$clog2(max_rob_depth)-1:0] rob_tag_t;

    // bit 3 set marks the immediate form
    typedef enum logic [3:0] {
        add    = 4'h0,
        sub    = 4'h1,
        and_op = 4'h2,
        or_op  = 4'h3,
        xor_op = 4'h4,
        mul    = 4'h5,
        addi   = 4'h8,
        xori   = 4'h9
    } opcode_t;

    typedef struct packed {
        opcode_t   opcode;
        arch_idx_t rd;
        arch_idx_t rs1;
        arch_idx_t rs2;
        logic [6:0] unused;
    } r_form_t;

    typedef struct packed {
        opcode_t    opcode;
        arch_idx_t  rd;
        arch_idx_t  rs1;
        logic [9:0] imm;            // signed
    } i_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } inst_word_u;

    typedef struct packed {
        logic                  ready;
        rob_tag_t              tag;     // producer while not ready
        logic [data_width-1:0] value;
    } operand_t;

    typedef struct packed {
        opcode_t  opcode;
        rob_tag_t tag;                  // destination
        operand_t src1;
        operand_t src2;
    } rs_entry_t;

    typedef struct packed {
        logic                  valid;
        rob_tag_t              tag;
        logic [data_width-1:0] value;
    } cdb_t;

    // issue packet
    typedef struct packed {
        logic                  valid;
        opcode_t               opcode;
        rob_tag_t              tag;
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
    } exec_req_t;

    typedef struct packed {
        logic                  valid;
        arch_idx_t             rd;
        logic [data_width-1:0] value;
    } commit_t;

    // everything except mul, which has its own unit
    function automatic logic [data_width-1:0] alu_result(
        input opcode_t               op,
        input logic [data_width-1:0] a,
        input logic [data_width-1:0] b
    );
        case (op)
            add, addi: return a + b;
            sub:       return a - b;
            and_op:    return a & b;
            or_op:     return a | b;
            xor_op,
            xori:      return a ^ b;
            default:   return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== src/rename_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_table (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      dispatch_valid,
    input  ooo_pkg::inst_word_u            dispatch_inst,
    input  ooo_pkg::rob_tag_t              dispatch_tag,
    input  wire logic [ooo_pkg::max_rob_depth-1:0] rob_done,
    input  wire logic [ooo_pkg::max_rob_depth-1:0][ooo_pkg::data_width-1:0] rob_values,
    input  ooo_pkg::cdb_t                  cdb,
    input  ooo_pkg::commit_t               retire,
    input  ooo_pkg::rob_tag_t              retire_tag,
    output ooo_pkg::operand_t              src1,
    output ooo_pkg::operand_t              src2
);
    import ooo_pkg::*;

    logic [data_width-1:0] arf [arch_regs];
    logic [arch_regs-1:0]  map_busy;
    rob_tag_t              map_tag [arch_regs];

    opcode_t               opcode;
    arch_idx_t             rd;
    arch_idx_t             src_idx [2];
    logic [9:0]            imm;
    operand_t              look [2];

    // same word, two views
    assign opcode     = dispatch_inst.r_form.opcode;
    assign rd         = dispatch_inst.r_form.rd;
    assign src_idx[0] = dispatch_inst.r_form.rs1;
    assign src_idx[1] = dispatch_inst.r_form.rs2;
    assign imm        = dispatch_inst.i_form.imm;

    // arf, then rob, then the bus in flight, else wait on the tag
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            look[s].ready = 1'b1;
            look[s].tag   = map_tag[src_idx[s]];
            look[s].value = '0;
            if (!map_busy[src_idx[s]])
                look[s].value = arf[src_idx[s]];
            else if (rob_done[look[s].tag])
                look[s].value = rob_values[look[s].tag];
            else if (cdb.valid && cdb.tag == look[s].tag)
                look[s].value = cdb.value;
            else
                look[s].ready = 1'b0;
        end
    end

    assign src1 = look[0];
    assign src2 = opcode[3] ? '{ready: 1'b1, tag: '0,
                                value: {{(data_width-10){imm[9]}}, imm}}
                            : look[1];

    always_ff @(posedge clock) begin
        if (reset) begin
            map_busy <= '0;
            for (int r = 0; r < arch_regs; r++)
                arf[r] <= '0;
        end else begin
            if (retire.valid) begin
                arf[retire.rd] <= retire.value;
                if (map_tag[retire.rd] == retire_tag)
                    map_busy[retire.rd] <= 1'b0;    // only if not renamed since
            end
            if (dispatch_valid) begin              // later write, new mapping wins
                map_busy[rd] <= 1'b1;
                map_tag[rd]  <= dispatch_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/reorder_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  wire logic                                  clock,
    input  wire logic                                  reset,
    input  wire logic                                  alloc_valid,
    input  ooo_pkg::arch_idx_t                         alloc_rd,
    input  ooo_pkg::cdb_t                              cdb,
    output logic                                       full,
    output ooo_pkg::rob_tag_t                          alloc_tag,
    output logic [ooo_pkg::max_rob_depth-1:0]          done,
    output logic [ooo_pkg::max_rob_depth-1:0][ooo_pkg::data_width-1:0] values,
    output ooo_pkg::commit_t                           retire,
    output ooo_pkg::rob_tag_t                          retire_tag
);
    import ooo_pkg::*;

    rob_tag_t                             head, tail;
    logic [$clog2(max_rob_depth+1)-1:0]   count;
    arch_idx_t                            rd_mem [max_rob_depth];
    logic                                 retire_fire;

    function automatic rob_tag_t bump(input rob_tag_t p);
        return (p == rob_tag_t'(ROB_DEPTH-1)) ? '0 : p + 1'b1;
    endfunction

    assign full        = (count == ROB_DEPTH);
    assign alloc_tag   = tail;
    assign retire_fire = (count != 0) && done[head];

    ////////////////////////////////////////////////////////////
    // pointers, done flags, retire register
    always_ff @(posedge clock) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            done         <= '0;
            retire.valid <= 1'b0;
        end else begin
            if (alloc_valid) begin
                tail       <= bump(tail);
                done[tail] <= 1'b0;   // stays set after retire until reused
            end
            if (cdb.valid)
                done[cdb.tag] <= 1'b1;
            if (retire_fire)
                head <= bump(head);
            count        <= count + alloc_valid - retire_fire;
            retire.valid <= retire_fire;
        end
        if (alloc_valid)
            rd_mem[tail] <= alloc_rd;
        if (cdb.valid)
            values[cdb.tag] <= cdb.value;
        retire.rd    <= rd_mem[head];
        retire.value <= values[head];
        retire_tag   <= head;
    end

endmodule

`default_nettype wire

// ==== src/reservation_station.sv ====
`timescale 1ns/100ps
`default_nettype none

module reservation_station #(
    parameter int RS_DEPTH = 4
) (
    input  wire logic          clock,
    input  wire logic          reset,
    input  wire logic          insert_valid,
    input  ooo_pkg::rs_entry_t insert,
    input  ooo_pkg::cdb_t      cdb,
    input  wire logic          alu_busy,
    output logic               full,
    output ooo_pkg::exec_req_t alu_req,
    output ooo_pkg::exec_req_t mult_req
);
    import ooo_pkg::*;

    localparam int slot_w = $clog2(RS_DEPTH);

    rs_entry_t                              entries [RS_DEPTH];
    logic [RS_DEPTH-1:0]                    valid;
    logic [RS_DEPTH-1:0][RS_DEPTH-1:0]      older;     // [i][j]: i came before j
    logic [RS_DEPTH-1:0]                    alu_cand, mul_cand;
    logic [RS_DEPTH-1:0]                    alu_pick, mul_pick;
    logic [slot_w-1:0]                      ins_slot;

    function automatic exec_req_t to_req(input rs_entry_t e);
        return '{valid: 1'b1, opcode: e.opcode, tag: e.tag,
                 a: e.src1.value, b: e.src2.value};
    endfunction

    assign full = &valid;

    ////////////////////////////////////////////////////////////
    // oldest ready entry per unit
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            alu_cand[i] = valid[i] && entries[i].src1.ready && entries[i].src2.ready
                          && entries[i].opcode != mul && !alu_busy;
            mul_cand[i] = valid[i] && entries[i].src1.ready && entries[i].src2.ready
                          && entries[i].opcode == mul;
        end
        alu_pick = alu_cand;
        mul_pick = mul_cand;
        for (int i = 0; i < RS_DEPTH; i++)
            for (int j = 0; j < RS_DEPTH; j++) begin
                if (alu_cand[j] && older[j][i]) alu_pick[i] = 1'b0;
                if (mul_cand[j] && older[j][i]) mul_pick[i] = 1'b0;
            end
        alu_req  = '0;
        mult_req = '0;
        ins_slot = '0;
        for (int i = RS_DEPTH-1; i >= 0; i--) begin
            if (alu_pick[i]) alu_req  = to_req(entries[i]);
            if (mul_pick[i]) mult_req = to_req(entries[i]);
            if (!valid[i])   ins_slot = slot_w'(i);   // lowest free slot
        end
    end

    ////////////////////////////////////////////////////////////
    // storage, wakeup and age
    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            valid <= valid & ~(alu_pick | mul_pick);
            if (insert_valid && !full)
                valid[ins_slot] <= 1'b1;
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (cdb.valid && !entries[i].src1.ready && entries[i].src1.tag == cdb.tag) begin
                entries[i].src1.ready <= 1'b1;
                entries[i].src1.value <= cdb.value;
            end
            if (cdb.valid && !entries[i].src2.ready && entries[i].src2.tag == cdb.tag) begin
                entries[i].src2.ready <= 1'b1;
                entries[i].src2.value <= cdb.value;
            end
        end
        if (insert_valid && !full) begin
            entries[ins_slot] <= insert;
            for (int j = 0; j < RS_DEPTH; j++) begin
                older[ins_slot][j] <= 1'b0;
                older[j][ins_slot] <= valid[j];   // everything present is older
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module clock_gen #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 8
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;                      // released on an edge
    end

endmodule

`default_nettype wire

// ==== verification/commit_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module commit_checker #(
    parameter int n_rows         = 24,
    parameter int commit_timeout = 200
) (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire logic                          in_ready,
    input  wire ooo_pkg::commit_t              commit,
    input  wire ooo_pkg::commit_t [n_rows-1:0] expected,
    output logic                               done,
    output int                                 checked,
    output int                                 errors
);
    import ooo_pkg::*;

    int check_errors;
    int stray_errors = 0;
    int commit_count = 0;

    assign errors = check_errors + stray_errors;

    task automatic compare_row(input int row);
        logic ok;
        ok = 1'b1;
        if (commit.rd !== expected[row].rd) begin
            $display("mismatch at %0t: commit.rd row %0d expected %0d got %0d",
                     $time, row, expected[row].rd, commit.rd);
            ok = 1'b0;
        end
        if (commit.value !== expected[row].value) begin
            $display("mismatch at %0t: commit.value row %0d expected %h got %h",
                     $time, row, expected[row].value, commit.value);
            ok = 1'b0;
        end
        if (ok)
            $display("row %0d ok: r%0d = %h at %0t", row, commit.rd, commit.value, $time);
        else
            check_errors++;
        checked++;
    endtask

    ////////////////////////////////////////////////////////////
    // commits taken in order, one table row each
    initial begin : compare
        int   waited;
        logic lost;
        done         = 1'b0;
        checked      = 0;
        check_errors = 0;
        waited       = 0;
        lost         = 1'b0;
        @(posedge clock);
        while (reset && waited < commit_timeout) begin
            @(posedge clock);
            waited++;
        end
        if (reset) begin
            $display("reset was never released");
            check_errors++;
            lost = 1'b1;
        end else if (in_ready !== 1'b1) begin
            $display("in_ready is not high right after reset at %0t", $time);
            check_errors++;
        end
        for (int row = 0; row < n_rows && !lost; row++) begin
            waited = 0;
            @(posedge clock);
            while (commit.valid !== 1'b1 && waited < commit_timeout) begin
                @(posedge clock);
                waited++;
            end
            if (commit.valid !== 1'b1) begin
                $display("row %0d: no commit arrived within %0d cycles", row, commit_timeout);
                check_errors++;
                lost = 1'b1;
            end else begin
                compare_row(row);
            end
        end
        done = 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // stray commits, during reset or past the last row
    always @(posedge clock) begin
        if (reset) begin
            if (commit.valid === 1'b1) begin
                $display("a commit appeared during reset at %0t", $time);
                stray_errors++;
            end
        end else if (commit.valid === 1'b1) begin
            commit_count++;
            if (commit_count > n_rows) begin
                $display("an extra commit appeared after the last row at %0t", $time);
                stray_errors++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/ooo_core_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module ooo_core_properties (
    input wire logic                clock,
    input wire logic                reset,
    input wire ooo_pkg::inst_word_u in_inst,
    input wire logic                in_valid,
    input wire logic                in_ready,
    input wire ooo_pkg::commit_t    commit,
    input wire logic                rob_full,
    input wire logic                alu_grant,
    input wire ooo_pkg::cdb_t       alu_cdb
);
    import ooo_pkg::*;

    commit_quiet_after_reset: assert property (@(posedge clock) reset |=> !commit.valid)
        else $error("commit.valid high right after a reset cycle");

    // refused alu result waits unchanged for the bus
    alu_result_held: assert property (@(posedge clock) disable iff (reset)
        alu_cdb.valid && !alu_grant |=> alu_cdb.valid && $stable(alu_cdb))
        else $error("alu result changed or dropped while waiting for the bus");

    rob_fills_only_on_dispatch: assert property (@(posedge clock) disable iff (reset)
        $rose(rob_full) |-> $past(in_valid && in_ready))
        else $error("reorder buffer became full without a dispatch");

    inst_held_while_stalled: assert property (@(posedge clock) disable iff (reset)
        in_valid && !in_ready |=> $stable(in_inst))
        else $error("in_inst changed while the input was stalled");

endmodule

`default_nettype wire

// ==== verification/tb_ooo_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int n_rows        = 24;
    localparam int ready_timeout = 200;
    localparam int done_timeout  = 4000;
    localparam int drain_cycles  = 30;

    typedef struct packed {
        inst_word_u inst;
        commit_t    want;
        logic       burst;                  // no idle gap before this row
    } stim_row_t;

    logic                    clock, reset;
    inst_word_u              in_inst;
    logic                    in_valid, in_ready;
    commit_t                 commit;
    commit_t [n_rows-1:0]    expected_commits;
    stim_row_t               stim [n_rows];
    int                      fill = 0;
    integer                  seed;
    logic                    checker_done;
    int                      rows_checked, error_count;

    clock_gen #(.half_period(10), .reset_cycles(8)) i_clock_gen (
        .clock(clock), .reset(reset)
    );

    ooo_core #(.ROB_DEPTH(8), .RS_DEPTH(4), .MULT_LATENCY(3)) i_ooo_core (
        .clock(clock), .reset(reset), .in_inst(in_inst), .in_valid(in_valid),
        .in_ready(in_ready), .commit(commit)
    );

    commit_checker #(.n_rows(n_rows), .commit_timeout(200)) i_commit_checker (
        .clock(clock), .reset(reset), .in_ready(in_ready), .commit(commit),
        .expected(expected_commits), .done(checker_done), .checked(rows_checked),
        .errors(error_count)
    );

    bind ooo_core ooo_core_properties i_ooo_core_properties (
        .clock(clock), .reset(reset), .in_inst(in_inst), .in_valid(in_valid),
        .in_ready(in_ready), .commit(commit), .rob_full(rob_full),
        .alu_grant(alu_grant), .alu_cdb(alu_cdb)
    );

    function automatic inst_word_u encode_r(input opcode_t op, input arch_idx_t rd,
                                            input arch_idx_t rs1, input arch_idx_t rs2);
        inst_word_u w;
        w.r_form = '{opcode: op, rd: rd, rs1: rs1, rs2: rs2, unused: '0};
        return w;
    endfunction

    function automatic inst_word_u encode_i(input opcode_t op, input arch_idx_t rd,
                                            input arch_idx_t rs1, input logic [9:0] imm);
        inst_word_u w;
        w.i_form = '{opcode: op, rd: rd, rs1: rs1, imm: imm};
        return w;
    endfunction

    task automatic put_row(input inst_word_u inst, input arch_idx_t rd,
                           input logic [15:0] value, input logic burst);
        stim[fill] = '{inst: inst, want: '{valid: 1'b1, rd: rd, value: value}, burst: burst};
        fill++;
    endtask

    initial begin
        int   waited;
        int   gap;
        int   stalls;
        logic drive_lost;
        logic failed;
        ////////////////////////////////////////////////////////////
        // immediates from zeroed registers
        put_row(encode_i(addi, 3'd1, 3'd0, 10'd5), 3'd1, 16'h0005, 1'b0);
        put_row(encode_i(xori, 3'd2, 3'd0, 10'h3ff), 3'd2, 16'hffff, 1'b0);
        put_row(encode_i(addi, 3'd3, 3'd0, 10'd300), 3'd3, 16'h012c, 1'b0);
        put_row(encode_i(addi, 3'd4, 3'd0, 10'h3f9), 3'd4, 16'hfff9, 1'b0);   // -7
        // dependent register chain
        put_row(encode_r(add, 3'd5, 3'd1, 3'd3), 3'd5, 16'h0131, 1'b1);
        put_row(encode_r(sub, 3'd6, 3'd5, 3'd1), 3'd6, 16'h012c, 1'b1);
        put_row(encode_r(and_op, 3'd7, 3'd6, 3'd2), 3'd7, 16'h012c, 1'b1);
        put_row(encode_r(or_op, 3'd1, 3'd7, 3'd4), 3'd1, 16'hfffd, 1'b1);
        put_row(encode_r(xor_op, 3'd5, 3'd1, 3'd5), 3'd5, 16'hfecc, 1'b1);
        put_row(encode_r(sub, 3'd6, 3'd0, 3'd1), 3'd6, 16'h0003, 1'b0);
        // mul, then independent alu work
        put_row(encode_r(mul, 3'd7, 3'd5, 3'd6), 3'd7, 16'hfc64, 1'b0);
        put_row(encode_i(addi, 3'd2, 3'd0, 10'd17), 3'd2, 16'h0011, 1'b1);
        put_row(encode_i(xori, 3'd3, 3'd3, 10'h00f), 3'd3, 16'h0123, 1'b1);
        put_row(encode_r(add, 3'd4, 3'd2, 3'd3), 3'd4, 16'h0134, 1'b1);
        // back to back dependent muls
        put_row(encode_r(mul, 3'd1, 3'd7, 3'd6), 3'd1, 16'hf52c, 1'b0);
        put_row(encode_r(mul, 3'd1, 3'd1, 3'd6), 3'd1, 16'hdf84, 1'b1);
        put_row(encode_r(mul, 3'd2, 3'd1, 3'd2), 3'd2, 16'hd7c4, 1'b1);
        put_row(encode_r(mul, 3'd1, 3'd2, 3'd6), 3'd1, 16'h874c, 1'b1);
        put_row(encode_r(mul, 3'd3, 3'd1, 3'd1), 3'd3, 16'h3e90, 1'b1);
        put_row(encode_r(mul, 3'd4, 3'd3, 3'd6), 3'd4, 16'hbbb0, 1'b1);
        // r5 rewritten while its mul is still pending
        put_row(encode_r(mul, 3'd5, 3'd4, 3'd6), 3'd5, 16'h3310, 1'b0);
        put_row(encode_i(addi, 3'd5, 3'd0, 10'd9), 3'd5, 16'h0009, 1'b1);
        put_row(encode_r(add, 3'd6, 3'd5, 3'd5), 3'd6, 16'h0012, 1'b1);
        put_row(encode_r(xor_op, 3'd7, 3'd5, 3'd4), 3'd7, 16'hbbb9, 1'b1);
        for (int i = 0; i < n_rows; i++)
            expected_commits[i] = stim[i].want;

        in_valid   = 1'b0;
        in_inst    = '0;
        seed       = 32'h6d38;
        drive_lost = 1'b0;
        waited     = 0;
        stalls     = 0;
        @(posedge clock);
        while (reset && waited < ready_timeout) begin
            @(posedge clock);
            waited++;
        end

        ////////////////////////////////////////////////////////////
        // drive loop, one handshake per row
        for (int row = 0; row < n_rows && !drive_lost && !reset; row++) begin
            gap = stim[row].burst ? 0 : ($random(seed) & 32'h3);
            if (gap > 0) begin
                in_valid <= 1'b0;
                repeat (gap) @(posedge clock);
            end
            in_valid <= 1'b1;
            in_inst  <= stim[row].inst;
            waited = 0;
            @(posedge clock);
            while (!in_ready && waited < ready_timeout) begin
                @(posedge clock);
                waited++;
                stalls++;
            end
            if (!in_ready) begin
                $display("row %0d: in_ready stayed low for %0d cycles", row, ready_timeout);
                drive_lost = 1'b1;
            end
        end
        in_valid <= 1'b0;
        if (stalls == 0)
            $display("in_ready never dropped during the mul burst");

        waited = 0;
        while (!checker_done && waited < done_timeout) begin
            @(posedge clock);
            waited++;
        end
        if (!checker_done)
            $display("the commit checker did not finish within %0d cycles", done_timeout);
        repeat (drain_cycles) @(posedge clock);   // room for stray commits

        failed = reset || drive_lost || !checker_done || error_count != 0
                 || rows_checked != n_rows || stalls == 0;
        $display("rows checked %0d of %0d, errors %0d", rows_checked, n_rows, error_count);
        if (failed) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

`default_nettype wire
